// File: vlog.f
+incdir+include
rtl/rom_pkg.sv
rtl/rom_addr_map.sv
rtl/rom_read_arbiter.sv
rtl/rom_fetch_top.sv
dv/sdram_model.sv
dv/tb_rom_fetch.sv

// File: Makefile
# Verilator build and run of the ROM read port testbench

VERILATOR ?= verilator
TOP       ?= tb_rom_fetch
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_rom_fetch.sv
/* Random CPU, fix and loader traffic on the shared ROM read port, checked against
   a reference of the address map. One fixed seed, ends by a cycle limit at worst. */

`timescale 1ns/100ps
`default_nettype none

`include "rom_defs.svh"

module tb_rom_fetch
	import rom_pkg::*;
();

	// 400 transactions of at most 30 cycles each
	localparam int MAX_CYCLES = 400 * 30;

	logic                      clk_sys;
	logic                      nBNKB;
	logic                      cpu_req;
	cpu_region_e               cpu_region;
	logic [`ROM_CPU_AW-1:0]    cpu_addr;
	logic                      cpu_ack;
	logic [`ROM_WORD_W-1:0]    cpu_data;
	logic                      fix_req;
	logic [`ROM_FIX_AW-1:0]    fix_latch;
	logic                      fix_ack;
	logic [`ROM_WORD_W-1:0]    fix_data;
	logic                      bank_wr;
	logic [`ROM_BANK_W-1:0]    bank_data;
	logic                      load_active;
	logic [`ROM_LOAD_IW-1:0]   load_index;
	logic [`ROM_LOAD_AW-1:0]   load_addr;
	logic                      load_wr;
	logic [`ROM_WORD_W-1:0]    load_data;
	logic [`ROM_SDRAM_AW-1:0]  sdram_addr;
	logic [`ROM_WORD_W-1:0]    sdram_din;
	logic                      sdram_we;
	logic                      sdram_rd;
	logic                      sdram_ready;
	logic [`ROM_SDRAM_DW-1:0]  sdram_dout;

	// Reference state
	logic [`ROM_BANK_W-1:0]   bank_ref = '0;
	logic [`ROM_SDRAM_AW-1:0] cpu_exp_addr = '0;
	logic [`ROM_SDRAM_AW-1:0] fix_exp_addr = '0;
	logic                     cpu_ack_q = 1'b0;
	logic                     fix_ack_q = 1'b0;
	int                       cpu_rd_seen = 0;
	int                       fix_rd_seen = 0;
	int                       cpu_ack_seen = 0;
	int                       fix_ack_seen = 0;
	int                       err_count = 0;
	int                       cycles = 0;

	rom_fetch_top dut_i (.*);
	sdram_model mem_i (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ==================================================
	// Reference address rules
	// ==================================================
	function automatic logic [`ROM_SDRAM_AW-1:0] cpu_byte_addr(input cpu_region_e r,
		input logic [`ROM_CPU_AW-1:0] a, input logic [`ROM_BANK_W-1:0] b);
		logic [`ROM_SDRAM_AW-1:0] twice;
		twice = `ROM_SDRAM_AW'(a) << 1;
		case (r)
			CPU_SYS: return `ROM_SYS_BASE + (`ROM_SDRAM_AW'(a[15:0]) << 1);
			CPU_P2:  return (`ROM_SDRAM_AW'(b) + 1) * `ROM_P2_BASE_STEP + twice;
			default: return twice;
		endcase
	endfunction

	function automatic logic [`ROM_SDRAM_AW-1:0] fix_byte_addr(input logic [`ROM_FIX_AW-1:0] l);
		logic [`ROM_FIX_AW-1:0] w;
		// Bits 2..0 shift up one, inverted bit 3 lands at bit 0
		w = (l & 16'hFFF0) | ((l & 16'h0007) << 1) | {15'd0, ~l[3]};
		return `ROM_FIX_BASE + (`ROM_SDRAM_AW'(w) << 1);
	endfunction

	function automatic logic [`ROM_SDRAM_AW-1:0] load_base(input logic [`ROM_LOAD_IW-1:0] idx);
		case (idx)
			`ROM_LIDX_SYS: return `ROM_SYS_BASE;
			`ROM_LIDX_P1B: return `ROM_P1B_OFFSET;
			`ROM_LIDX_P2:  return `ROM_P2_BASE_STEP;
			`ROM_LIDX_FIX: return `ROM_FIX_BASE;
			default:       return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp)
		begin
			err_count++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic report(input string msg);
		err_count++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	// Four-phase rule on one client, sampled mid-cycle
	task automatic check_handshake(input string name, input logic req, input logic ack,
		input logic ack_q, inout int acks);
		if (ack && !ack_q)
		begin
			acks++;
			if (!req)
				report({name, " rose while its req was low"});
			if (acks > 1)
				report({name, " rose twice for one req"});
			if (load_active)
				report({name, " rose during a load"});
		end
		if (!ack && ack_q && req)
			report({name, " fell while its req was still high"});
	endtask

	always @(negedge clk_sys)
	begin
		if (nBNKB)
		begin
			if (sdram_rd)
			begin
				if (load_active)
					report("read pulse during a load");
				// Client address ranges never overlap
				if (cpu_req && sdram_addr == cpu_exp_addr)
					cpu_rd_seen++;
				else if (fix_req && sdram_addr == fix_exp_addr)
					fix_rd_seen++;
				else
					report($sformatf("read at unexpected sdram_addr %h", sdram_addr));
			end
			check_handshake("cpu_ack", cpu_req, cpu_ack, cpu_ack_q, cpu_ack_seen);
			check_handshake("fix_ack", fix_req, fix_ack, fix_ack_q, fix_ack_seen);
			cpu_ack_q = cpu_ack;
			fix_ack_q = fix_ack;
		end
	end

	// ==================================================
	// Client and loader drivers
	// ==================================================
	task automatic write_bank(input logic [`ROM_BANK_W-1:0] b);
		@(posedge clk_sys);
		bank_wr <= 1'b1;
		bank_data <= b;
		@(posedge clk_sys);
		bank_wr <= 1'b0;
		bank_ref = b;
	endtask

	task automatic cpu_read(input cpu_region_e r, input logic [`ROM_CPU_AW-1:0] a, input int hold);
		@(posedge clk_sys);
		cpu_exp_addr = cpu_byte_addr(r, a, bank_ref);
		cpu_rd_seen = 0;
		cpu_ack_seen = 0;
		cpu_region <= r;
		cpu_addr <= a;
		cpu_req <= 1'b1;
		@(negedge clk_sys);
		while (!cpu_ack)
			@(negedge clk_sys);
		check_value("cpu_data", 32'(cpu_exp_addr[15:0] ^ 16'hA5C3), 32'(cpu_data));
		// Held req must not start a second read
		repeat (hold) @(negedge clk_sys);
		@(posedge clk_sys);
		cpu_req <= 1'b0;
		@(negedge clk_sys);
		while (cpu_ack)
			@(negedge clk_sys);
		check_value("cpu sdram_rd count", 1, cpu_rd_seen);
	endtask

	task automatic fix_read(input logic [`ROM_FIX_AW-1:0] l, input int hold);
		@(posedge clk_sys);
		fix_exp_addr = fix_byte_addr(l);
		fix_rd_seen = 0;
		fix_ack_seen = 0;
		fix_latch <= l;
		fix_req <= 1'b1;
		@(negedge clk_sys);
		while (!fix_ack)
			@(negedge clk_sys);
		check_value("fix_data", 32'(fix_exp_addr[15:0] ^ 16'hA5C3), 32'(fix_data));
		repeat (hold) @(negedge clk_sys);
		@(posedge clk_sys);
		fix_req <= 1'b0;
		@(negedge clk_sys);
		while (fix_ack)
			@(negedge clk_sys);
		check_value("fix sdram_rd count", 1, fix_rd_seen);
	endtask

	task automatic random_cpu(input int hold);
		cpu_region_e r;
		r = cpu_region_e'($urandom_range(2));
		if ($urandom_range(1) == 1)
			write_bank(`ROM_BANK_W'($urandom));
		cpu_read(r, `ROM_CPU_AW'($urandom), hold);
	endtask

	task automatic load_burst(input int n);
		logic [`ROM_SDRAM_AW+`ROM_WORD_W-1:0] wr_exp[$];
		logic [`ROM_SDRAM_AW+`ROM_WORD_W-1:0] entry;
		logic [`ROM_LOAD_IW-1:0]              idx;
		logic [`ROM_LOAD_AW-1:0]              a;
		logic [`ROM_WORD_W-1:0]               d;
		int                                   base;
		base = mem_i.wr_log.size();
		@(posedge clk_sys);
		load_active <= 1'b1;
		for (int i = 0; i < n; i++)
		begin
			// Indexes 1, 2, 3, 7 and 9 lie outside SDRAM
			idx = `ROM_LOAD_IW'($urandom_range(9));
			a = `ROM_LOAD_AW'($urandom) & 25'h01FFFFE;
			d = `ROM_WORD_W'($urandom);
			@(posedge clk_sys);
			load_index <= idx;
			load_addr <= a;
			load_data <= d;
			load_wr <= 1'b1;
			@(posedge clk_sys);
			load_wr <= 1'b0;
			if (idx inside {`ROM_LIDX_SYS, `ROM_LIDX_P1A, `ROM_LIDX_P1B, `ROM_LIDX_P2, `ROM_LIDX_FIX})
				wr_exp.push_back({a + load_base(idx), d});
		end
		@(posedge clk_sys);
		load_active <= 1'b0;
		@(negedge clk_sys);
		check_value("sdram_we count", wr_exp.size(), mem_i.wr_log.size() - base);
		for (int i = 0; i < wr_exp.size() && base + i < mem_i.wr_log.size(); i++)
		begin
			entry = mem_i.wr_log[base + i];
			check_value("sdram_addr", 32'(wr_exp[i][`ROM_WORD_W +: `ROM_SDRAM_AW]),
				32'(entry[`ROM_WORD_W +: `ROM_SDRAM_AW]));
			check_value("sdram_din", 32'(wr_exp[i][`ROM_WORD_W-1:0]), 32'(entry[`ROM_WORD_W-1:0]));
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial
	begin
		void'($urandom(32'h865c));
		nBNKB = 1'b0;
		cpu_req = 1'b0;
		cpu_region = CPU_P1;
		cpu_addr = '0;
		fix_req = 1'b0;
		fix_latch = '0;
		bank_wr = 1'b0;
		bank_data = '0;
		load_active = 1'b0;
		load_index = '0;
		load_addr = '0;
		load_wr = 1'b0;
		load_data = '0;
		repeat (5) @(posedge clk_sys);
		nBNKB <= 1'b1;
		@(negedge clk_sys);
		check_value("cpu_ack", 0, 32'(cpu_ack));
		check_value("fix_ack", 0, 32'(fix_ack));
		check_value("sdram_rd", 0, 32'(sdram_rd));
		check_value("sdram_we", 0, 32'(sdram_we));
		// First P2 read relies on the bank coming out of reset as 0
		cpu_read(CPU_P2, `ROM_CPU_AW'($urandom), 0);
		repeat (120) random_cpu(0);
		repeat (80) fix_read(`ROM_FIX_AW'($urandom), 0);
		// Overlapping clients with a small random skew
		repeat (60)
		begin
			fork
				begin
					repeat ($urandom_range(3)) @(posedge clk_sys);
					random_cpu(0);
				end
				begin
					repeat ($urandom_range(3)) @(posedge clk_sys);
					fix_read(`ROM_FIX_AW'($urandom), 0);
				end
			join
		end
		// Held requests, longer than any read latency
		repeat (10) random_cpu(12 + $urandom_range(8));
		repeat (5) fix_read(`ROM_FIX_AW'($urandom), 15);
		// Requests raised inside a load burst wait for its end
		repeat (4)
		begin
			fork
				load_burst(12);
				begin
					repeat (3) @(posedge clk_sys);
					fork
						random_cpu(0);
						fix_read(`ROM_FIX_AW'($urandom), 0);
					join
				end
			join
		end
		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d in checks, %0d in SDRAM protocol, after %0d cycles",
			err_count, mem_i.bad_rd_count, cycles);
		if (err_count + mem_i.bad_rd_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/sdram_model.sv
/* Behavioral SDRAM for the ROM read port testbench. Read data comes from the address,
   nothing is stored. Ready drops after a read and returns 2 to 9 cycles later. */

`timescale 1ns/100ps
`default_nettype none

`include "rom_defs.svh"

module sdram_model
(
	input  logic                      clk_sys,
	input  logic                      nBNKB,
	input  logic [`ROM_SDRAM_AW-1:0]  sdram_addr,
	input  logic [`ROM_WORD_W-1:0]    sdram_din,
	input  logic                      sdram_we,
	input  logic                      sdram_rd,
	output logic                      sdram_ready,
	output logic [`ROM_SDRAM_DW-1:0]  sdram_dout
);

	logic [`ROM_SDRAM_AW-1:0] rd_addr;
	logic [3:0]               wait_cnt;
	// Every write seen, address above data
	logic [`ROM_SDRAM_AW+`ROM_WORD_W-1:0] wr_log[$];
	int                       bad_rd_count;

	// Upper word is the only part the DUT uses
	function automatic logic [`ROM_SDRAM_DW-1:0] read_word(input logic [`ROM_SDRAM_AW-1:0] a);
		return {a[15:0] ^ 16'hA5C3, 23'd0, a};
	endfunction

	// ==================================================
	// Read timing and write log
	// ==================================================
	always @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			sdram_ready <= 1'b1;
			sdram_dout <= '0;
			rd_addr <= '0;
			wait_cnt <= '0;
			bad_rd_count <= 0;
		end
		else
		begin
			if (sdram_rd && !sdram_ready)
			begin
				bad_rd_count <= bad_rd_count + 1;
				$display("** Error at %0t: read pulse while the SDRAM was busy", $time);
			end
			else if (sdram_rd)
			begin
				rd_addr <= sdram_addr;
				sdram_ready <= 1'b0;
				wait_cnt <= 4'(2 + $urandom_range(7));
			end
			else if (!sdram_ready)
			begin
				// Data valid together with the ready rise
				if (wait_cnt <= 4'd1)
				begin
					sdram_ready <= 1'b1;
					sdram_dout <= read_word(rd_addr);
				end
				else
					wait_cnt <= wait_cnt - 4'd1;
			end
			if (sdram_we)
				wr_log.push_back({sdram_addr, sdram_din});
		end
	end

endmodule

`default_nettype wire

// File: rtl/rom_fetch_top.sv
/* SDRAM read port shared by CPU program fetch and fix tile fetch, plus the ROM
   loader write path. Clients must follow the four-phase req/ack rule. */

`timescale 1ns/100ps
`default_nettype none

`include "rom_defs.svh"

module rom_fetch_top
	import rom_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      nBNKB,
	// CPU client
	input  logic                      cpu_req,
	input  cpu_region_e               cpu_region,
	input  logic [`ROM_CPU_AW-1:0]    cpu_addr,
	output logic                      cpu_ack,
	output logic [`ROM_WORD_W-1:0]    cpu_data,
	// Fix client
	input  logic                      fix_req,
	input  logic [`ROM_FIX_AW-1:0]    fix_latch,
	output logic                      fix_ack,
	output logic [`ROM_WORD_W-1:0]    fix_data,
	// P2 bank write
	input  logic                      bank_wr,
	input  logic [`ROM_BANK_W-1:0]    bank_data,
	// ROM loader
	input  logic                      load_active,
	input  logic [`ROM_LOAD_IW-1:0]   load_index,
	input  logic [`ROM_LOAD_AW-1:0]   load_addr,
	input  logic                      load_wr,
	input  logic [`ROM_WORD_W-1:0]    load_data,
	// SDRAM port
	output logic [`ROM_SDRAM_AW-1:0]  sdram_addr,
	output logic [`ROM_WORD_W-1:0]    sdram_din,
	output logic                      sdram_we,
	output logic                      sdram_rd,
	input  logic                      sdram_ready,
	input  logic [`ROM_SDRAM_DW-1:0]  sdram_dout
);

	// Owner of the running read, selects the address source
	arb_state_e arb_state;

	rom_read_arbiter arb_i (
		.clk_sys     (clk_sys),
		.nBNKB       (nBNKB),
		.cpu_req     (cpu_req),
		.fix_req     (fix_req),
		.load_active (load_active),
		.sdram_ready (sdram_ready),
		.sdram_dout  (sdram_dout),
		.cpu_ack     (cpu_ack),
		.fix_ack     (fix_ack),
		.cpu_data    (cpu_data),
		.fix_data    (fix_data),
		.sdram_rd    (sdram_rd),
		.arb_state   (arb_state)
	);

	rom_addr_map map_i (
		.clk_sys     (clk_sys),
		.nBNKB       (nBNKB),
		.arb_state   (arb_state),
		.cpu_region  (cpu_region),
		.cpu_addr    (cpu_addr),
		.fix_latch   (fix_latch),
		.bank_wr     (bank_wr),
		.bank_data   (bank_data),
		.load_active (load_active),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_wr     (load_wr),
		.load_data   (load_data),
		.sdram_addr  (sdram_addr),
		.sdram_din   (sdram_din),
		.sdram_we    (sdram_we)
	);

endmodule

`default_nettype wire

// File: rtl/rom_read_arbiter.sv
/* Shares one SDRAM read port between CPU and fix fetcher with req/ack handshakes.
   Assumes ready drops the cycle after a read and rises again with data valid. */

`timescale 1ns/100ps
`default_nettype none

`include "rom_defs.svh"

module rom_read_arbiter
	import rom_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      nBNKB,
	input  logic                      cpu_req,
	input  logic                      fix_req,
	input  logic                      load_active,
	input  logic                      sdram_ready,
	input  logic [`ROM_SDRAM_DW-1:0]  sdram_dout,
	output logic                      cpu_ack,
	output logic                      fix_ack,
	output logic [`ROM_WORD_W-1:0]    cpu_data,
	output logic [`ROM_WORD_W-1:0]    fix_data,
	output logic                      sdram_rd,
	output arb_state_e                arb_state
);

	logic [1:0] cpu_req_sr;
	logic [1:0] fix_req_sr;
	logic [1:0] ready_sr;
	logic       cpu_pend;
	logic       fix_pend;
	logic       rd_pulse;
	logic       want_cpu;
	logic       want_fix;
	logic       port_free;
	logic       rd_abort;
	logic       rd_done;

	// Requests seen as registered rising edges
	assign want_cpu = cpu_pend | (cpu_req_sr == 2'b01);
	assign want_fix = fix_pend | (fix_req_sr == 2'b01);
	// Port is free once idle, ready, not loading and no ack still up
	assign port_free = (arb_state == ARB_IDLE) & sdram_ready & ~rd_pulse
		& ~load_active & ~cpu_ack & ~fix_ack;
	// Loader took the port in the pulse cycle, so the read never left
	assign rd_abort = rd_pulse & load_active;
	assign rd_done = (ready_sr == 2'b01) & ~rd_pulse & (arb_state != ARB_IDLE);
	assign sdram_rd = rd_pulse & ~load_active;

	// ==================================================
	// Issue, completion and handshake control
	// ==================================================
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			cpu_req_sr <= 2'b00;
			fix_req_sr <= 2'b00;
			ready_sr <= 2'b00;
			cpu_pend <= 1'b0;
			fix_pend <= 1'b0;
			rd_pulse <= 1'b0;
			cpu_ack <= 1'b0;
			fix_ack <= 1'b0;
			arb_state <= ARB_IDLE;
		end
		else
		begin
			cpu_req_sr <= {cpu_req_sr[0], cpu_req};
			fix_req_sr <= {fix_req_sr[0], fix_req};
			ready_sr <= {ready_sr[0], sdram_ready};
			rd_pulse <= 1'b0;
			cpu_pend <= want_cpu;
			fix_pend <= want_fix;
			// Fix fetch wins a tie
			if (port_free && want_fix)
			begin
				fix_pend <= 1'b0;
				rd_pulse <= 1'b1;
				arb_state <= ARB_FIX_RUN;
			end
			else if (port_free && want_cpu)
			begin
				cpu_pend <= 1'b0;
				rd_pulse <= 1'b1;
				arb_state <= ARB_CPU_RUN;
			end
			// Put the owner back in line
			if (rd_abort)
			begin
				arb_state <= ARB_IDLE;
				if (arb_state == ARB_CPU_RUN)
					cpu_pend <= 1'b1;
				else
					fix_pend <= 1'b1;
			end
			if (rd_done)
			begin
				arb_state <= ARB_IDLE;
				if (arb_state == ARB_CPU_RUN)
					cpu_ack <= 1'b1;
				else
					fix_ack <= 1'b1;
			end
			// Ack drops once the registered req is low
			if (!cpu_req_sr[0])
				cpu_ack <= 1'b0;
			if (!fix_req_sr[0])
				fix_ack <= 1'b0;
		end
	end

	// Upper word of the SDRAM burst goes to the owner
	always_ff @(posedge clk_sys)
	begin
		if (rd_done && arb_state == ARB_CPU_RUN)
			cpu_data <= sdram_dout[`ROM_SDRAM_DW-1 -: `ROM_WORD_W];
		if (rd_done && arb_state == ARB_FIX_RUN)
			fix_data <= sdram_dout[`ROM_SDRAM_DW-1 -: `ROM_WORD_W];
	end

	// ==================================================
	// Protocol checks
	// ==================================================
	// Reads only start on an idle memory
	a_rd_legal: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		sdram_rd |-> sdram_ready);
	a_one_ack: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		!(cpu_ack && fix_ack));
	// Ack holds while its req is still up
	a_cpu_ack_hold: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		cpu_ack && cpu_req |=> cpu_ack);
	a_fix_ack_hold: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		fix_ack && fix_req |=> fix_ack);

endmodule

`default_nettype wire

// File: rtl/rom_addr_map.sv
/* Combinational SDRAM address, write data and write enable for the shared port.
   The loader overrides the read path; only the P2 bank is registered. */

`timescale 1ns/100ps
`default_nettype none

`include "rom_defs.svh"

module rom_addr_map
	import rom_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      nBNKB,
	input  arb_state_e                arb_state,
	input  cpu_region_e               cpu_region,
	input  logic [`ROM_CPU_AW-1:0]    cpu_addr,
	input  logic [`ROM_FIX_AW-1:0]    fix_latch,
	input  logic                      bank_wr,
	input  logic [`ROM_BANK_W-1:0]    bank_data,
	input  logic                      load_active,
	input  logic [`ROM_LOAD_IW-1:0]   load_index,
	input  logic [`ROM_LOAD_AW-1:0]   load_addr,
	input  logic                      load_wr,
	input  logic [`ROM_WORD_W-1:0]    load_data,
	output logic [`ROM_SDRAM_AW-1:0]  sdram_addr,
	output logic [`ROM_WORD_W-1:0]    sdram_din,
	output logic                      sdram_we
);

	logic [`ROM_BANK_W-1:0]   p2_bank;
	logic [`ROM_BANK_W:0]     p2_slot;
	logic [`ROM_SDRAM_AW-1:0] cpu_byte;
	logic [`ROM_SDRAM_AW-1:0] load_offset;
	logic [`ROM_FIX_AW-1:0]   fix_word;
	load_region_e             load_region;

	// P2 bank register loaded by each bank_wr pulse
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			p2_bank <= '0;
		else if (bank_wr)
			p2_bank <= bank_data;
	end

	// Bank 0 sits right after P1
	assign p2_slot = {1'b0, p2_bank} + 1'b1;
	assign cpu_byte = {{(`ROM_SDRAM_AW-`ROM_CPU_AW-1){1'b0}}, cpu_addr, 1'b0};
	// Latch bit 3 picks the tile half and lands inverted at the word LSB
	assign fix_word = {fix_latch[15:4], fix_latch[2:0], ~fix_latch[3]};

	// ==================================================
	// Loader region decode
	// ==================================================
	always_comb
	begin
		case (load_index)
			`ROM_LIDX_SYS: load_region = LD_SYS;
			`ROM_LIDX_P1A: load_region = LD_P1A;
			`ROM_LIDX_P1B: load_region = LD_P1B;
			`ROM_LIDX_P2:  load_region = LD_P2;
			`ROM_LIDX_FIX: load_region = LD_FIX;
			default:       load_region = LD_OTHER;
		endcase
	end

	always_comb
	begin
		case (load_region)
			LD_SYS:  load_offset = `ROM_SYS_BASE;
			LD_P1B:  load_offset = `ROM_P1B_OFFSET;
			LD_P2:   load_offset = `ROM_P2_BASE_STEP;
			LD_FIX:  load_offset = `ROM_FIX_BASE;
			default: load_offset = '0;
		endcase
	end

	// Regions outside SDRAM never write
	assign sdram_we = (load_active && load_region != LD_OTHER) ? load_wr : 1'b0;
	assign sdram_din = load_active ? load_data : '0;

	// ==================================================
	// Read address of the running client
	// ==================================================
	always_comb
	begin
		sdram_addr = '0;
		if (load_active)
			sdram_addr = load_addr + load_offset;
		else if (arb_state == ARB_CPU_RUN)
		begin
			case (cpu_region)
				// System ROM is 128k so upper CPU bits are ignored
				CPU_SYS: sdram_addr = `ROM_SYS_BASE + {cpu_addr[15:0], 1'b0};
				CPU_P2:  sdram_addr = `ROM_SDRAM_AW'(p2_slot) * `ROM_P2_BASE_STEP + cpu_byte;
				default: sdram_addr = cpu_byte;
			endcase
		end
		else if (arb_state == ARB_FIX_RUN)
			sdram_addr = `ROM_FIX_BASE + {fix_word, 1'b0};
	end

	// Loader writes land on whole words
	a_we_aligned: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		sdram_we |-> !sdram_addr[0]);

endmodule

`default_nettype wire

// File: rtl/rom_pkg.sv
/* Types shared by the ROM read port. Loader index values come from the defs
   header, any index not listed here is treated as a region outside SDRAM. */

`default_nettype none

`include "rom_defs.svh"

package rom_pkg;

	// Region the CPU is reading from
	typedef enum logic [1:0] {
		CPU_P1,
		CPU_P2,
		CPU_SYS
	} cpu_region_e;

	// Owner of the read now running on the SDRAM port
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CPU_RUN,
		ARB_FIX_RUN
	} arb_state_e;

	// Loader index decoded to an SDRAM region
	typedef enum logic [`ROM_LOAD_IW-1:0] {
		LD_SYS   = `ROM_LIDX_SYS,
		LD_P1A   = `ROM_LIDX_P1A,
		LD_P1B   = `ROM_LIDX_P1B,
		LD_P2    = `ROM_LIDX_P2,
		LD_FIX   = `ROM_LIDX_FIX,
		LD_OTHER = 8'hFF
	} load_region_e;

endpackage

`default_nettype wire

// File: include/rom_defs.svh
/* Widths, SDRAM region bases and loader indexes for the shared ROM read port.
   SDRAM addresses are byte addresses with bit 0 always zero for word reads. */

`ifndef ROM_DEFS_SVH
`define ROM_DEFS_SVH

// ==================================================
// Bus widths
// ==================================================
`define ROM_SDRAM_AW 25
`define ROM_SDRAM_DW 64
`define ROM_WORD_W 16
// CPU word address, one bit short of the byte address
`define ROM_CPU_AW 19
`define ROM_FIX_AW 16
`define ROM_BANK_W 2
`define ROM_LOAD_AW 25
`define ROM_LOAD_IW 8

// ==================================================
// SDRAM layout
// ==================================================
// System ROM 0800000~081FFFF
`define ROM_SYS_BASE 25'h0800000
// P2 banks follow P1, one MiB each
`define ROM_P2_BASE_STEP 25'h0100000
// S ROM 0820000~083FFFF
`define ROM_FIX_BASE 25'h0820000
`define ROM_P1B_OFFSET 25'h0080000

// Loader indexes of the regions kept in SDRAM
`define ROM_LIDX_SYS 8'd0
`define ROM_LIDX_P1A 8'd4
`define ROM_LIDX_P1B 8'd5
`define ROM_LIDX_P2 8'd6
`define ROM_LIDX_FIX 8'd8

`endif
